// File: source/a2_card_pkg.sv
// ****************************
// Apple II card shared definitions
// Bus timing counts, slot decode constants and enums
// ****************************
`default_nettype none

package a2_card_pkg;

    // Logic clock cycles in one half of the 1.023 MHz bus period
    localparam int PHASE_COUNT = 24;

    // Point in Phi1 where the 6502 address and R/W have settled on the bus
    localparam int ADDR_SAMPLE_COUNT = 18;

    // Point in Phi0 where write data is stable, about 300 ns into the phase
    localparam int DATA_SAMPLE_COUNT = 15;

    // The phase counter stops here when Phi0 has stopped toggling
    localparam int SLEEP_COUNT = 63;

    // Slot the card is plugged into
    localparam int CARD_SLOT = 4;

    // The sixteen device-select bytes of a slot start at C080 + 16 * slot
    localparam logic [15:0] DEVSEL_BASE = 16'hC080 + 16'(16 * CARD_SLOT);

    // Bit 0 of this register drives the interrupt request line
    localparam logic [3:0] IRQ_REG = 4'd15;

    // Half of the bus cycle we are currently in
    typedef enum logic {
        PH_PHI1 = 1'b0,
        PH_PHI0 = 1'b1
    } bus_phase_e;

    // Decoded kind of the access that was just sampled
    typedef enum logic [1:0] {
        ACC_NONE  = 2'd0,
        ACC_READ  = 2'd1,
        ACC_WRITE = 2'd2
    } bus_access_e;

endpackage

`default_nettype wire

// File: source/a2bus_if.sv
// ****************************
// Apple II card internal interfaces
// Sampled bus bundle and synchronized control lines
// ****************************
`timescale 1ns/1ps
`default_nettype none

interface a2bus_if;
    import a2_card_pkg::*;

    // Logic clock, driven by the card top level
    logic       clk;
    // Latched address, data and R/W of the current bus cycle
    logic [15:0] addr;
    logic [7:0] data;
    logic       rw_n;
    // Current half of the bus cycle
    bus_phase_e phase;
    // One cycle pulse once the data byte of a bus cycle has been sampled
    logic       data_in_strobe;

    modport sampler (
        input  clk,
        output addr, data, rw_n, phase, data_in_strobe
    );

    modport decoder (
        input clk, addr, data, rw_n, phase, data_in_strobe
    );
endinterface

interface a2ctrl_if;
    // Bus control lines, already in the logic clock domain
    logic inh_n;
    logic rdy_n;
    logic dma_n;
    logic nmi_n;
    logic reset_n;

    modport source (output inh_n, rdy_n, dma_n, nmi_n, reset_n);
    modport sink (input inh_n, rdy_n, dma_n, nmi_n, reset_n);
endinterface

`default_nettype wire

// File: source/bus_sampler.sv
// ****************************
// Apple II bus sampler
// Tracks Phi0 and latches address and data at tuned counts
// ****************************
`timescale 1ns/1ps
`default_nettype none

module bus_sampler (
    a2bus_if.sampler   bus,
    input  logic        rst_n_i,
    input  logic        a2_phi0_i,
    input  logic [15:0] a2_a_i,
    input  logic [7:0]  a2_d_i,
    input  logic        a2_rw_n_i,
    output logic        sleep_o
);
    import a2_card_pkg::*;

    // Counter wide enough to hold the saturation value
    typedef logic [$clog2(SLEEP_COUNT + 1) - 1:0] cnt_t;

    logic [1:0]  phi0_sync_q;
    logic        phi0_q;
    logic        phi0_edge_w;
    cnt_t        phase_cnt_q;
    bus_phase_e  phase_w;
    logic        addr_sample_w;
    logic        data_sample_w;
    logic [15:0] addr_q;
    logic        rw_n_q;
    logic [7:0]  data_q;
    logic        strobe_q;

    // Phi0 is asynchronous to the logic clock, so it passes two flops first
    always_ff @(posedge bus.clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phi0_sync_q <= 2'b00;
            phi0_q      <= 1'b0;
        end else begin
            phi0_sync_q <= {phi0_sync_q[0], a2_phi0_i};
            phi0_q      <= phi0_sync_q[1];
        end
    end

    // Either edge of Phi0 starts a new phase
    assign phi0_edge_w = phi0_sync_q[1] ^ phi0_q;

    // After an edge phi0_q already holds the new level, matching the zero count
    assign phase_w = phi0_q ? PH_PHI0 : PH_PHI1;

    // Cycles since the last phase change, held at the top when the bus stops
    always_ff @(posedge bus.clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            phase_cnt_q <= '0;
        end else if (phi0_edge_w) begin
            phase_cnt_q <= '0;
        end else if (phase_cnt_q != cnt_t'(SLEEP_COUNT)) begin
            phase_cnt_q <= phase_cnt_q + 1'b1;
        end
    end

    assign addr_sample_w = (phase_w == PH_PHI1) && (phase_cnt_q == cnt_t'(ADDR_SAMPLE_COUNT));
    assign data_sample_w = (phase_w == PH_PHI0) && (phase_cnt_q == cnt_t'(DATA_SAMPLE_COUNT));

    // Address and R/W hold from one Phi1 sample to the next
    // They start out as a read outside any slot so an early strobe decodes to nothing
    always_ff @(posedge bus.clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            addr_q <= '0;
            rw_n_q <= 1'b1;
        end else if (addr_sample_w) begin
            addr_q <= a2_a_i;
            rw_n_q <= a2_rw_n_i;
        end
    end

    // Only a write cycle carries data from the CPU
    always_ff @(posedge bus.clk) begin
        if (data_sample_w && !rw_n_q) begin
            data_q <= a2_d_i;
        end
    end

    // The strobe marks every bus cycle, reads included
    always_ff @(posedge bus.clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            strobe_q <= 1'b0;
        end else begin
            strobe_q <= data_sample_w;
        end
    end

    assign bus.addr           = addr_q;
    assign bus.rw_n           = rw_n_q;
    assign bus.data           = data_q;
    assign bus.phase          = phase_w;
    assign bus.data_in_strobe = strobe_q;

    // A counter parked at the top means Phi0 has gone quiet
    assign sleep_o = (phase_cnt_q == cnt_t'(SLEEP_COUNT));

endmodule

`default_nettype wire

// File: source/control_sync.sv
// ****************************
// Apple II control line synchronizer
// Also passes the priority daisy chains through
// ****************************
`timescale 1ns/1ps
`default_nettype none

module control_sync (
    input  logic clk_i,
    input  logic rst_n_i,
    a2ctrl_if.source ctrl,
    input  logic a2_inh_n_i,
    input  logic a2_rdy_n_i,
    input  logic a2_dma_n_i,
    input  logic a2_nmi_n_i,
    input  logic a2_reset_n_i,
    input  logic a2_int_in_n_i,
    input  logic a2_dma_in_n_i,
    output logic a2_int_out_n_o,
    output logic a2_dma_out_n_o
);

    logic [4:0] ctrl_pins_w;
    logic [4:0] meta_q;
    logic [4:0] sync_q;

    // Bit order is inh, rdy, dma, nmi, reset from high to low
    assign ctrl_pins_w = {a2_inh_n_i, a2_rdy_n_i, a2_dma_n_i, a2_nmi_n_i, a2_reset_n_i};

    // Two flops per line
    // All lines are active low, so they come out of reset released
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            meta_q <= '1;
            sync_q <= '1;
        end else begin
            meta_q <= ctrl_pins_w;
            sync_q <= meta_q;
        end
    end

    assign ctrl.inh_n   = sync_q[4];
    assign ctrl.rdy_n   = sync_q[3];
    assign ctrl.dma_n   = sync_q[2];
    assign ctrl.nmi_n   = sync_q[1];
    assign ctrl.reset_n = sync_q[0];

    // The card never claims interrupt or DMA priority
    // Lower slots keep their place in the chain without any delay
    assign a2_int_out_n_o = a2_int_in_n_i;
    assign a2_dma_out_n_o = a2_dma_in_n_i;

endmodule

`default_nettype wire

// File: source/slot_decoder.sv
// ****************************
// Apple II device-select decoder
// Sixteen byte register file with interrupt request bit
// ****************************
`timescale 1ns/1ps
`default_nettype none

module slot_decoder (
    a2bus_if.decoder  bus,
    a2ctrl_if.sink    ctrl,
    input  logic       rst_n_i,
    input  logic [3:0] reg_sel_i,
    output logic [7:0] reg_rdata_o,
    output logic       reg_wr_o,
    output logic       dev_rd_o,
    output logic [3:0] reg_idx_o,
    output logic       irq_n_o
);
    import a2_card_pkg::*;

    logic        in_range_w;
    bus_access_e access_w;
    logic [7:0]  regs_q [16];
    logic        reg_wr_q;
    logic        dev_rd_q;
    logic [3:0]  reg_idx_q;

    // The base sits on a 16 byte boundary, so the upper 12 bits pick the slot
    assign in_range_w = (bus.addr[15:4] == DEVSEL_BASE[15:4]);

    // Classify the access once its data has been sampled
    // Nothing is decoded while the Apple is held in reset
    // A read with RDY low is a wait cycle that the CPU repeats, so it is skipped
    always_comb begin
        access_w = ACC_NONE;
        if (bus.data_in_strobe && ctrl.reset_n && in_range_w) begin
            if (!bus.rw_n) begin
                access_w = ACC_WRITE;
            end else if (ctrl.rdy_n) begin
                access_w = ACC_READ;
            end
        end
    end

    // Register file, wiped by either the card reset or the Apple reset line
    always_ff @(posedge bus.clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (!ctrl.reset_n) begin
            for (int i = 0; i < 16; i++) begin
                regs_q[i] <= '0;
            end
        end else if (access_w == ACC_WRITE) begin
            regs_q[bus.addr[3:0]] <= bus.data;
        end
    end

    // Event pulses line up with the register update
    always_ff @(posedge bus.clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            reg_wr_q  <= 1'b0;
            dev_rd_q  <= 1'b0;
            reg_idx_q <= '0;
        end else begin
            reg_wr_q <= (access_w == ACC_WRITE);
            dev_rd_q <= (access_w == ACC_READ);
            if (access_w != ACC_NONE) begin
                reg_idx_q <= bus.addr[3:0];
            end
        end
    end

    assign reg_wr_o    = reg_wr_q;
    assign dev_rd_o    = dev_rd_q;
    assign reg_idx_o   = reg_idx_q;
    assign reg_rdata_o = regs_q[reg_sel_i];

    // Software raises the interrupt by setting bit 0 of the IRQ register
    assign irq_n_o = ~regs_q[IRQ_REG][0];

endmodule

`default_nettype wire

// File: source/a2_card_top.sv
// ****************************
// Apple II expansion card front end
// Joins sampler, control sync and slot decoder
// ****************************
`timescale 1ns/1ps
`default_nettype none

module a2_card_top (
    input  logic        a2bus_clk_i,
    input  logic        rst_n_i,
    // Apple II bus pins
    input  logic        a2_phi0_i,
    input  logic [15:0] a2_a_i,
    input  logic [7:0]  a2_d_i,
    input  logic        a2_rw_n_i,
    input  logic        a2_inh_n_i,
    input  logic        a2_rdy_n_i,
    input  logic        a2_dma_n_i,
    input  logic        a2_nmi_n_i,
    input  logic        a2_reset_n_i,
    input  logic        a2_int_in_n_i,
    input  logic        a2_dma_in_n_i,
    output logic        a2_int_out_n_o,
    output logic        a2_dma_out_n_o,
    // Card side
    input  logic [3:0]  reg_sel_i,
    output logic [7:0]  reg_rdata_o,
    output logic        reg_wr_o,
    output logic        dev_rd_o,
    output logic [3:0]  reg_idx_o,
    output logic        irq_n_o,
    output logic        sleep_o
);

    a2bus_if  bus_if ();
    a2ctrl_if ctrl_if ();

    // Every block runs on the same logic clock
    assign bus_if.clk = a2bus_clk_i;

    bus_sampler u_bus_sampler (
        .bus       (bus_if.sampler),
        .rst_n_i   (rst_n_i),
        .a2_phi0_i (a2_phi0_i),
        .a2_a_i    (a2_a_i),
        .a2_d_i    (a2_d_i),
        .a2_rw_n_i (a2_rw_n_i),
        .sleep_o   (sleep_o)
    );

    control_sync u_control_sync (
        .clk_i          (a2bus_clk_i),
        .rst_n_i        (rst_n_i),
        .ctrl           (ctrl_if.source),
        .a2_inh_n_i     (a2_inh_n_i),
        .a2_rdy_n_i     (a2_rdy_n_i),
        .a2_dma_n_i     (a2_dma_n_i),
        .a2_nmi_n_i     (a2_nmi_n_i),
        .a2_reset_n_i   (a2_reset_n_i),
        .a2_int_in_n_i  (a2_int_in_n_i),
        .a2_dma_in_n_i  (a2_dma_in_n_i),
        .a2_int_out_n_o (a2_int_out_n_o),
        .a2_dma_out_n_o (a2_dma_out_n_o)
    );

    slot_decoder u_slot_decoder (
        .bus         (bus_if.decoder),
        .ctrl        (ctrl_if.sink),
        .rst_n_i     (rst_n_i),
        .reg_sel_i   (reg_sel_i),
        .reg_rdata_o (reg_rdata_o),
        .reg_wr_o    (reg_wr_o),
        .dev_rd_o    (dev_rd_o),
        .reg_idx_o   (reg_idx_o),
        .irq_n_o     (irq_n_o)
    );

endmodule

`default_nettype wire

// File: verification/a2_card_properties.sv
// ****************************
// Apple II card port properties
// Event pulses, interrupt source and daisy chain
// ****************************
`timescale 1ns/1ps
`default_nettype none

module a2_card_properties (
    input logic       clk_i,
    input logic       rst_n_i,
    input logic       reg_wr_i,
    input logic       dev_rd_i,
    input logic [3:0] reg_idx_i,
    input logic       irq_n_i,
    input logic       int_in_n_i,
    input logic       int_out_n_i,
    input logic       dma_in_n_i,
    input logic       dma_out_n_i
);
    import a2_card_pkg::*;

    // Number of assertion failures, read by the testbench at the end
    int fail_count = 0;

    // Each bus cycle gives at most one single cycle event
    a_wr_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        reg_wr_i |=> !reg_wr_i)
        else begin
            fail_count++;
            $error("reg_wr_o stayed high for more than one cycle");
        end

    a_rd_pulse: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        dev_rd_i |=> !dev_rd_i)
        else begin
            fail_count++;
            $error("dev_rd_o stayed high for more than one cycle");
        end

    // The interrupt request is only raised by a write to the IRQ register
    a_irq_source: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $fell(irq_n_i) |-> (reg_wr_i && reg_idx_i == IRQ_REG))
        else begin
            fail_count++;
            $error("irq_n_o fell without a write to the IRQ register");
        end

    // Priority chains pass straight through the card
    a_int_chain: assert property (@(posedge clk_i) int_out_n_i == int_in_n_i)
        else begin
            fail_count++;
            $error("Interrupt chain output differs from its input");
        end

    a_dma_chain: assert property (@(posedge clk_i) dma_out_n_i == dma_in_n_i)
        else begin
            fail_count++;
            $error("DMA chain output differs from its input");
        end

endmodule

`default_nettype wire

// File: verification/a2_card_tb.sv
// ****************************
// Apple II card testbench
// Runs bus cycles against the card and checks its events
// ****************************
`timescale 1ns/1ps
`default_nettype none

module a2_card_tb;
    import a2_card_pkg::*;

    // Run length in bus cycles, with room for reset and the sleep wait
    localparam int BUS_CYCLES     = 60;
    localparam int MARGIN_CYCLES  = 300;
    localparam int TIMEOUT_CYCLES = BUS_CYCLES * 2 * PHASE_COUNT + MARGIN_CYCLES;

    logic        clk;
    logic        rst_n;
    logic        a2_phi0;
    logic [15:0] a2_a;
    logic [7:0]  a2_d;
    logic        a2_rw_n;
    logic        a2_inh_n;
    logic        a2_rdy_n;
    logic        a2_dma_n;
    logic        a2_nmi_n;
    logic        a2_reset_n;
    logic        a2_int_in_n;
    logic        a2_dma_in_n;
    logic        a2_int_out_n;
    logic        a2_dma_out_n;
    logic [3:0]  reg_sel;
    logic [7:0]  reg_rdata;
    logic        reg_wr;
    logic        dev_rd;
    logic [3:0]  reg_idx;
    logic        irq_n;
    logic        sleep;

    // Register contents expected from the writes issued so far
    logic [7:0]  exp_regs [16];
    logic [3:0]  last_wr_idx;
    logic [3:0]  last_rd_idx;
    logic [15:0] addr;
    logic [7:0]  wdata;
    integer      seed;
    int          wr_pulses;
    int          rd_pulses;
    int          wr0;
    int          rd0;
    int          fails0;
    int          check_count;
    int          error_count;
    int          cycle_count;
    int          wait_cycles;

    a2_card_top UUT (
        .a2bus_clk_i (clk),          .rst_n_i        (rst_n),
        .a2_phi0_i   (a2_phi0),      .a2_a_i         (a2_a),
        .a2_d_i      (a2_d),         .a2_rw_n_i      (a2_rw_n),
        .a2_inh_n_i  (a2_inh_n),     .a2_rdy_n_i     (a2_rdy_n),
        .a2_dma_n_i  (a2_dma_n),     .a2_nmi_n_i     (a2_nmi_n),
        .a2_reset_n_i(a2_reset_n),   .a2_int_in_n_i  (a2_int_in_n),
        .a2_dma_in_n_i(a2_dma_in_n), .a2_int_out_n_o (a2_int_out_n),
        .a2_dma_out_n_o(a2_dma_out_n), .reg_sel_i    (reg_sel),
        .reg_rdata_o (reg_rdata),    .reg_wr_o       (reg_wr),
        .dev_rd_o    (dev_rd),       .reg_idx_o      (reg_idx),
        .irq_n_o     (irq_n),        .sleep_o        (sleep)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Event pulses are counted at the falling edge, away from the DUT updates
    always @(negedge clk) begin
        if (rst_n && reg_wr) begin
            wr_pulses++;
            last_wr_idx = reg_idx;
        end
        if (rst_n && dev_rd) begin
            rd_pulses++;
            last_rd_idx = reg_idx;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    // Failures from the testbench and from the bound properties together
    function automatic int total_failures();
        return error_count + UUT.u_props.fail_count;
    endfunction

    task automatic drive_step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_value(input string what, input int got, input int expected);
        check_count++;
        assert (got == expected) else begin
            error_count++;
            $display("MISMATCH at %0t: %s is %0h, expected %0h", $time, what, got, expected);
        end
    endtask

    // One bus cycle: Phi1 carries address and R/W, Phi0 carries the data byte
    task automatic run_bus_cycle(input logic [15:0] a, input logic rw_n, input logic [7:0] d);
        drive_step();
        a2_phi0 = 1'b0;
        a2_a    = a;
        a2_rw_n = rw_n;
        repeat (PHASE_COUNT - 1) drive_step();
        drive_step();
        a2_phi0 = 1'b1;
        a2_d    = d;
        repeat (PHASE_COUNT - 1) drive_step();
    endtask

    task automatic expect_pulses(input string what, input int wr_exp, input int rd_exp);
        check_value({what, " reg_wr_o pulses"}, wr_pulses - wr0, wr_exp);
        check_value({what, " dev_rd_o pulses"}, rd_pulses - rd0, rd_exp);
    endtask

    task automatic verify_all_regs(input string what);
        for (int i = 0; i < 16; i++) begin
            reg_sel = 4'(i);
            #1;
            check_value($sformatf("%s register %0d", what, i), int'(reg_rdata),
                        int'(exp_regs[i]));
        end
    endtask

    task automatic report_test(input string name);
        if (total_failures() == fails0) begin
            $display("[%0t] %s: done, no failures", $time, name);
        end else begin
            $display("[%0t] %s: done, %0d failures", $time, name, total_failures() - fails0);
        end
        fails0 = total_failures();
        wr0 = wr_pulses;
        rd0 = rd_pulses;
    endtask

    initial begin
        seed = 32'ha621_c8d4;
        {wr_pulses, rd_pulses, wr0, rd0, fails0} = '0;
        {check_count, error_count, cycle_count, wait_cycles} = '0;
        // Phi0 starts high so the first bus cycle opens with a falling edge
        rst_n = 1'b0;
        a2_phi0 = 1'b1;
        a2_a = '0;
        a2_d = '0;
        a2_rw_n = 1'b1;
        {a2_inh_n, a2_rdy_n, a2_dma_n, a2_nmi_n, a2_reset_n} = 5'b11111;
        a2_int_in_n = 1'b1;
        a2_dma_in_n = 1'b1;
        reg_sel = '0;
        for (int i = 0; i < 16; i++) begin
            exp_regs[i] = '0;
        end
        repeat (2) drive_step();
        rst_n = 1'b1;
        drive_step();
        // Out of reset the card is idle, awake and holds an empty register file
        check_value("reg_wr_o after reset", int'(reg_wr), 0);
        check_value("dev_rd_o after reset", int'(dev_rd), 0);
        check_value("irq_n_o after reset", int'(irq_n), 1);
        check_value("sleep_o after reset", int'(sleep), 0);
        verify_all_regs("After reset");
        report_test("Reset");

        // Every device-select byte takes a random value and reads back through reg_sel_i
        for (int n = 0; n < 16; n++) begin
            wdata = 8'($random(seed));
            wr0 = wr_pulses;
            rd0 = rd_pulses;
            run_bus_cycle(DEVSEL_BASE + 16'(n), 1'b0, wdata);
            exp_regs[n] = wdata;
            expect_pulses("Write", 1, 0);
            check_value("Write reg_idx_o", int'(last_wr_idx), n);
            reg_sel = 4'(n);
            #1;
            check_value("Write read-back", int'(reg_rdata), int'(wdata));
        end
        report_test("Writes in the slot range");

        for (int n = 0; n < 16; n++) begin
            wr0 = wr_pulses;
            rd0 = rd_pulses;
            run_bus_cycle(DEVSEL_BASE + 16'(n), 1'b1, 8'($random(seed)));
            expect_pulses("Read", 0, 1);
            check_value("Read reg_idx_o", int'(last_rd_idx), n);
        end
        verify_all_regs("After reads");
        report_test("Reads in the slot range");

        // Random addresses that fall outside the sixteen device-select bytes
        for (int n = 0; n < 16; n++) begin
            do begin
                addr = 16'($random(seed));
            end while (addr >= DEVSEL_BASE && addr <= DEVSEL_BASE + 16'd15);
            run_bus_cycle(addr, 1'($random(seed)), 8'($random(seed)));
        end
        expect_pulses("Outside range", 0, 0);
        verify_all_regs("Outside range");
        report_test("Accesses outside the range");

        addr = DEVSEL_BASE + 16'(IRQ_REG);
        run_bus_cycle(addr, 1'b0, 8'h00);
        check_value("irq_n_o with IRQ bit clear", int'(irq_n), 1);
        run_bus_cycle(addr, 1'b0, 8'h01);
        check_value("irq_n_o with IRQ bit set", int'(irq_n), 0);
        run_bus_cycle(addr, 1'b0, 8'h00);
        check_value("irq_n_o after IRQ bit cleared", int'(irq_n), 1);
        exp_regs[IRQ_REG] = 8'h00;
        // Walk the daisy-chain inputs through all four combinations
        for (int k = 0; k < 4; k++) begin
            {a2_int_in_n, a2_dma_in_n} = 2'(k);
            #1;
            check_value("a2_int_out_n_o", int'(a2_int_out_n), int'(a2_int_in_n));
            check_value("a2_dma_out_n_o", int'(a2_dma_out_n), int'(a2_dma_in_n));
        end
        report_test("Interrupt request and daisy chain");

        // Known bytes first, the IRQ bit among them, so the clear has something to wipe
        run_bus_cycle(DEVSEL_BASE + 16'd3, 1'b0, 8'hA5);
        run_bus_cycle(DEVSEL_BASE + 16'(IRQ_REG), 1'b0, 8'h01);
        exp_regs[3] = 8'hA5;
        exp_regs[IRQ_REG] = 8'h01;
        check_value("irq_n_o before bus reset", int'(irq_n), 0);
        wr0 = wr_pulses;
        rd0 = rd_pulses;
        drive_step();
        a2_reset_n = 1'b0;
        for (int n = 0; n < 4; n++) begin
            run_bus_cycle(DEVSEL_BASE + 16'(n), 1'($random(seed)), 8'($random(seed)));
        end
        expect_pulses("Bus reset", 0, 0);
        drive_step();
        a2_reset_n = 1'b1;
        repeat (3) drive_step();
        for (int i = 0; i < 16; i++) begin
            exp_regs[i] = '0;
        end
        verify_all_regs("After bus reset");
        check_value("irq_n_o after bus reset", int'(irq_n), 1);
        report_test("Bus reset");

        // Phi0 falls once and then stays low, with an address of the next slot on the pins
        check_value("sleep_o while the bus runs", int'(sleep), 0);
        drive_step();
        a2_a = DEVSEL_BASE + 16'h0010;
        a2_rw_n = 1'b1;
        a2_phi0 = 1'b0;
        while (!sleep && wait_cycles < SLEEP_COUNT + 4) begin
            drive_step();
            wait_cycles++;
        end
        check_value("sleep_o after Phi0 stopped", int'(sleep), 1);
        drive_step();
        a2_phi0 = 1'b1;
        repeat (PHASE_COUNT - 1) drive_step();
        run_bus_cycle(DEVSEL_BASE + 16'h0010, 1'b1, 8'h00);
        check_value("sleep_o after Phi0 restarted", int'(sleep), 0);
        expect_pulses("Sleep", 0, 0);
        report_test("Sleep");

        $display("Summary: %0d checks, %0d testbench failures, %0d assertion failures",
                 check_count, error_count, UUT.u_props.fail_count);
        if (total_failures() == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

bind a2_card_top a2_card_properties u_props (
    .clk_i       (a2bus_clk_i),
    .rst_n_i     (rst_n_i),
    .reg_wr_i    (reg_wr_o),
    .dev_rd_i    (dev_rd_o),
    .reg_idx_i   (reg_idx_o),
    .irq_n_i     (irq_n_o),
    .int_in_n_i  (a2_int_in_n_i),
    .int_out_n_i (a2_int_out_n_o),
    .dma_in_n_i  (a2_dma_in_n_i),
    .dma_out_n_i (a2_dma_out_n_o)
);

`default_nettype wire

// File: a2_card_top.f
source/a2_card_pkg.sv
source/a2bus_if.sv
source/bus_sampler.sv
source/control_sync.sv
source/slot_decoder.sv
source/a2_card_top.sv
verification/a2_card_properties.sv
verification/a2_card_tb.sv

// File: Makefile
# Verilator build and run for the Apple II card testbench

VERILATOR ?= verilator
TOP       ?= a2_card_tb
FILELIST  ?= a2_card_top.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_TEXT ?= ALL CHECKS PASSED

SIM := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
